//--- build.f
+incdir+source
source/board_ctl_pkg.sv
source/spi_frame_rx.sv
source/mask_reg_bank.sv
source/spi_route_mux.sv
source/board_ctl_top.sv
dv/board_ctl_assertions.sv
dv/board_ctl_tb.sv

//--- Makefile
# Verilator flow for the board controller testbench

VERILATOR ?= verilator
TOP       ?= board_ctl_tb
RTL_TOP   ?= board_ctl_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/board_ctl_tb.sv
/*
  directed testbench for the board controller, spi master at clk/8
  a register model predicts ports and the miso readback of every frame
  miso is sampled on the clk falling edge just before each rising sclk
*/
`timescale 1ns/1ps

`include "board_ctl_defines.svh"

module board_ctl_tb;

  localparam int frame_cycles   = 8 * 17 + 16;   // longest frame plus cs_n idle
  localparam int max_frames     = 50;
  localparam int timeout_cycles = 2 * max_frames * frame_cycles;

  logic                      clk, arst_n;
  logic                      sclk, cs_n, mosi, special, miso;
  logic [`BC_NUM_PERIPH-1:0] periph_cs_n, periph_miso;
  logic [`BC_REG_BITS-1:0]   led, dac, rails, dac_ref_mux, adc;
  logic [`BC_REG_BITS-1:0]   clamp1, clamp2, relay_com, irange_sw, relay;

  logic [3:0] model_regs [256];   // indexed by address
  logic [7:0] model_last;         // addr of last valid frame
  integer     seed;
  int         errors, checks, cycle_cnt;
  string      test_name;

  board_ctl_top i_board_ctl_top (
    .clk (clk), .arst_n (arst_n),
    .sclk (sclk), .cs_n (cs_n), .mosi (mosi), .special (special), .miso (miso),
    .periph_cs_n (periph_cs_n), .periph_miso (periph_miso),
    .led (led), .dac (dac), .rails (rails), .dac_ref_mux (dac_ref_mux), .adc (adc),
    .clamp1 (clamp1), .clamp2 (clamp2), .relay_com (relay_com),
    .irange_sw (irange_sw), .relay (relay)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("ERROR: run did not finish within %0d cycles", timeout_cycles);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // register model

  function automatic logic [7:0] addr_at(input int idx);
    case (idx)
      0:       addr_at = `BC_ADDR_LED;
      1:       addr_at = `BC_ADDR_MUX;
      2:       addr_at = `BC_ADDR_DAC;
      3:       addr_at = `BC_ADDR_RAILS;
      4:       addr_at = `BC_ADDR_DAC_REF_MUX;
      5:       addr_at = `BC_ADDR_ADC;
      6:       addr_at = `BC_ADDR_CLAMP1;
      7:       addr_at = `BC_ADDR_CLAMP2;
      8:       addr_at = `BC_ADDR_RELAY_COM;
      9:       addr_at = `BC_ADDR_IRANGE_SW;
      default: addr_at = `BC_ADDR_RELAY;
    endcase
  endfunction

  function automatic logic is_reg_addr(input logic [7:0] a);
    is_reg_addr = 1'b0;
    for (int i = 0; i < `BC_NUM_REGS; i++)
    begin
      if (addr_at(i) == a)
        is_reg_addr = 1'b1;
    end
  endfunction

  // echo of last valid addr, contents only for real registers
  function automatic logic [15:0] model_reply();
    model_reply = {model_last, 8'h00};
    if (is_reg_addr(model_last))
      model_reply[3:0] = model_regs[model_last];
  endfunction

  function automatic void model_apply(input logic [15:0] f);
    logic [7:0] a;
    logic [3:0] clr_m, set_m, both;
    a     = f[15:8];
    clr_m = f[7:4];
    set_m = f[3:0];
    both  = clr_m & set_m;
    model_last = a;
    if (a == `BC_ADDR_SOFT_RST)
    begin
      for (int i = 0; i < 256; i++)
        model_regs[i] = 4'h0;
    end
    else if (is_reg_addr(a))
    begin
      if (both != 4'h0)
        model_regs[a] = model_regs[a] ^ both;   // shared bits toggle
      else
        model_regs[a] = (model_regs[a] | set_m) & ~clr_m;
    end
  endfunction

  //////////////////////////////////////////////////
  // checks

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic check_ports();
    @(negedge clk);
    check_eq({test_name, " led"}, 32'(model_regs[`BC_ADDR_LED]), 32'(led));
    check_eq({test_name, " dac"}, 32'(model_regs[`BC_ADDR_DAC]), 32'(dac));
    check_eq({test_name, " rails"}, 32'(model_regs[`BC_ADDR_RAILS]), 32'(rails));
    check_eq({test_name, " dac_ref_mux"}, 32'(model_regs[`BC_ADDR_DAC_REF_MUX]),
             32'(dac_ref_mux));
    check_eq({test_name, " adc"}, 32'(model_regs[`BC_ADDR_ADC]), 32'(adc));
    check_eq({test_name, " clamp1"}, 32'(model_regs[`BC_ADDR_CLAMP1]), 32'(clamp1));
    check_eq({test_name, " clamp2"}, 32'(model_regs[`BC_ADDR_CLAMP2]), 32'(clamp2));
    check_eq({test_name, " relay_com"}, 32'(model_regs[`BC_ADDR_RELAY_COM]), 32'(relay_com));
    check_eq({test_name, " irange_sw"}, 32'(model_regs[`BC_ADDR_IRANGE_SW]), 32'(irange_sw));
    check_eq({test_name, " relay"}, 32'(model_regs[`BC_ADDR_RELAY]), 32'(relay));
    check_eq({test_name, " periph_cs_n idle"}, 32'hF, 32'(periph_cs_n));
  endtask

  //////////////////////////////////////////////////
  // spi master

  // mode 0, 4 clk low then 4 clk high per bit, msb first
  task automatic spi_frame(input logic [31:0] bits, input int nbits, input logic spec,
                           output logic [31:0] rx);
    logic [31:0] cap;
    cap = '0;
    @(posedge clk);
    cs_n    <= 1'b0;
    special <= spec;
    sclk    <= 1'b0;
    mosi    <= bits[nbits-1];
    for (int i = nbits - 1; i >= 0; i--)
    begin
      repeat (3) @(posedge clk);
      @(negedge clk);                 // sdo settled, sclk about to rise
      cap = {cap[30:0], miso};
      if (!spec)
        check_eq({test_name, " periph_cs_n during write"}, 32'hF, 32'(periph_cs_n));
      @(posedge clk);
      sclk <= 1'b1;
      repeat (4) @(posedge clk);
      sclk <= 1'b0;
      if (i > 0)
        mosi <= bits[i-1];            // next bit on the falling edge
    end
    repeat (4) @(posedge clk);
    cs_n    <= 1'b1;
    special <= 1'b0;
    repeat (8) @(posedge clk);        // update lands 4 clk after cs_n rise
    rx = cap;
  endtask

  task automatic run_frame(input logic [31:0] bits, input int nbits, input logic spec);
    logic [31:0] exp_stream, rx;
    exp_stream = {model_reply(), 16'h0000} >> (32 - nbits);   // zeros after bit 16
    spi_frame(bits, nbits, spec, rx);
    if (!spec)
      check_eq({test_name, " readback"}, exp_stream, rx);
    if (nbits == `BC_FRAME_BITS && !spec)
      model_apply(bits[15:0]);
    check_ports();
  endtask

  task automatic write_reg(input logic [7:0] a, input logic [3:0] clr_m, input logic [3:0] set_m);
    run_frame({16'h0000, a, clr_m, set_m}, `BC_FRAME_BITS, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // tests

  task automatic reset_values();
    test_name = "reset_values";
    check_ports();
  endtask

  task automatic mask_updates();
    logic [7:0] a;
    test_name = "mask_updates";
    for (int k = 0; k < 3; k++)
    begin
      a = (k == 0) ? `BC_ADDR_LED : (k == 1) ? `BC_ADDR_RAILS : `BC_ADDR_RELAY;
      write_reg(a, 4'h0, 4'b1011);      // set only
      write_reg(a, 4'b0010, 4'h0);      // clear only
      write_reg(a, 4'b1000, 4'b0100);   // disjoint set and clear
      write_reg(a, 4'b0110, 4'b0110);   // overlap, toggle
    end
  endtask

  task automatic random_updates();
    logic [31:0] r;
    int          idx;
    test_name = "random_updates";
    for (int k = 0; k < 20; k++)
    begin
      r   = $random(seed);
      idx = r[31:16] % 11;
      write_reg(addr_at(idx), r[7:4], r[3:0]);
    end
  endtask

  task automatic soft_reset_and_bad_frames();
    test_name = "soft_reset";
    run_frame({16'h0000, `BC_ADDR_SOFT_RST, 8'h00}, `BC_FRAME_BITS, 1'b0);
    test_name = "bad_frames";
    write_reg(`BC_ADDR_LED, 4'h0, 4'b0110);      // reply of soft reset is 0
    write_reg(`BC_ADDR_RELAY, 4'h0, 4'b1001);
    run_frame(32'h0000_3F0F, 15, 1'b0);           // short
    run_frame(32'h0001_070F, 17, 1'b0);           // long
    run_frame({16'h0000, `BC_ADDR_LED, 8'h0F}, `BC_FRAME_BITS, 1'b1);   // special high
    run_frame({16'h0000, 8'd13, 8'h0F}, `BC_FRAME_BITS, 1'b0);          // hole in the map
    write_reg(`BC_ADDR_RELAY, 4'h0, 4'h0);       // readback of addr 13 is empty
  endtask

  task automatic peripheral_routing();
    logic [3:0] sel, pat;
    test_name = "routing";
    for (int k = 0; k < 3; k++)
    begin
      sel = (k == 0) ? 4'b0101 : (k == 1) ? 4'b1010 : 4'b1111;
      write_reg(`BC_ADDR_MUX, ~sel, sel);
      @(posedge clk);
      special <= 1'b1;
      cs_n    <= 1'b0;
      @(negedge clk);
      check_eq("routing periph_cs_n selected", {28'h0, ~sel}, 32'(periph_cs_n));
      for (int p = 0; p < 16; p++)
      begin
        pat = 4'(p);
        @(posedge clk);
        periph_miso <= pat;
        @(negedge clk);
        check_eq("routing miso", 32'(|(pat & sel)), 32'(miso));
      end
      @(posedge clk);
      cs_n <= 1'b1;
      @(negedge clk);
      check_eq("routing periph_cs_n released", 32'hF, 32'(periph_cs_n));
      @(posedge clk);
      special     <= 1'b0;
      periph_miso <= '0;
      repeat (4) @(posedge clk);
    end
    write_reg(`BC_ADDR_LED, 4'h0, 4'b1000);     // mux nonzero, write still hidden
  endtask

  //////////////////////////////////////////////////
  // main

  initial
  begin
    seed        = 32'h1e1710c7;
    errors      = 0;
    checks      = 0;
    cycle_cnt   = 0;
    model_last  = 8'h00;
    for (int i = 0; i < 256; i++)
      model_regs[i] = 4'h0;
    arst_n      = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    special     = 1'b0;
    periph_miso = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    reset_values();
    mask_updates();
    random_updates();
    soft_reset_and_bad_frames();
    peripheral_routing();
    repeat (4) @(posedge clk);
    errors += i_board_ctl_top.i_spi_frame_rx.i_rx_assertions.fail_cnt;
    errors += i_board_ctl_top.i_mask_reg_bank.i_bank_assertions.fail_cnt;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- dv/board_ctl_assertions.sv
/*
  concurrent checks bound into the receiver and the register bank
  inputs a bound instance does not use are tied to constants
  fail_cnt counts assertion failures for the testbench summary
*/
`timescale 1ns/1ps

`include "board_ctl_defines.svh"

module board_ctl_assertions (
  input logic                      clk,
  input logic                      arst_n,
  input logic                      frame_valid,
  input logic                      cs_n_sync,   // synchronized cs_n
  input logic [`BC_NUM_PERIPH-1:0] mux_sel
);

  int fail_cnt = 0;

  //////////////////////////////////////////////////
  // frame_valid shape

  a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    frame_valid |=> !frame_valid)
  else
  begin
    $error("frame_valid high for more than one cycle");
    fail_cnt++;
  end

  // only after cs_n is back high
  a_valid_cs_high: assert property (@(posedge clk) disable iff (!arst_n)
    frame_valid |-> cs_n_sync)
  else
  begin
    $error("frame_valid while synchronized cs_n is low");
    fail_cnt++;
  end

  //////////////////////////////////////////////////
  // register update timing

  a_mux_update: assert property (@(posedge clk) disable iff (!arst_n)
    !$stable(mux_sel) |-> $past(frame_valid))
  else
  begin
    $error("mux_sel changed without a frame_valid one cycle before");
    fail_cnt++;
  end

endmodule

// receiver side, mux never moves here
bind spi_frame_rx board_ctl_assertions i_rx_assertions (
  .clk         (clk),
  .arst_n      (arst_n),
  .frame_valid (frame_valid),
  .cs_n_sync   (cs_n_s2),
  .mux_sel     ({`BC_NUM_PERIPH{1'b0}})
);

// bank side, no view of cs_n
bind mask_reg_bank board_ctl_assertions i_bank_assertions (
  .clk         (clk),
  .arst_n      (arst_n),
  .frame_valid (frame_valid),
  .cs_n_sync   (1'b1),
  .mux_sel     (mux_sel)
);

//--- source/board_ctl_top.sv
/*
  board controller front end, spi register bank plus peripheral routing
  periph bit 0 adc03, 1 dac, 2 flash, 3 adc02
*/
`timescale 1ns/1ps

`include "board_ctl_defines.svh"

module board_ctl_top
  import board_ctl_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  // mcu spi
  input  logic                      sclk,
  input  logic                      cs_n,
  input  logic                      mosi,
  input  logic                      special,
  output logic                      miso,
  // routed peripherals
  output logic [`BC_NUM_PERIPH-1:0] periph_cs_n,
  input  logic [`BC_NUM_PERIPH-1:0] periph_miso,
  // control registers
  output logic [`BC_REG_BITS-1:0]   led,
  output logic [`BC_REG_BITS-1:0]   dac,
  output logic [`BC_REG_BITS-1:0]   rails,
  output logic [`BC_REG_BITS-1:0]   dac_ref_mux,
  output logic [`BC_REG_BITS-1:0]   adc,
  output logic [`BC_REG_BITS-1:0]   clamp1,
  output logic [`BC_REG_BITS-1:0]   clamp2,
  output logic [`BC_REG_BITS-1:0]   relay_com,
  output logic [`BC_REG_BITS-1:0]   irange_sw,
  output logic [`BC_REG_BITS-1:0]   relay
);

  spi_frame_u                frame;
  logic                      frame_valid;
  logic [`BC_FRAME_BITS-1:0] reply_word;
  logic [`BC_NUM_PERIPH-1:0] mux_sel;
  logic                      sdo;

  //////////////////////////////////////////////////
  // receiver

  spi_frame_rx i_spi_frame_rx (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special     (special),
    .reply_word  (reply_word),
    .sdo         (sdo),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  //////////////////////////////////////////////////
  // register bank

  mask_reg_bank i_mask_reg_bank (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .mux_sel     (mux_sel),
    .reply_word  (reply_word),
    .led         (led),
    .dac         (dac),
    .rails       (rails),
    .dac_ref_mux (dac_ref_mux),
    .adc         (adc),
    .clamp1      (clamp1),
    .clamp2      (clamp2),
    .relay_com   (relay_com),
    .irange_sw   (irange_sw),
    .relay       (relay)
  );

  // raw pins here, no clk latency on the pass-through
  spi_route_mux i_spi_route_mux (
    .special     (special),
    .cs_n        (cs_n),
    .sdo         (sdo),
    .mux_sel     (mux_sel),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

//--- source/spi_route_mux.sv
/*
  combinational chip select fan-out and miso return path
  special low keeps every peripheral deselected during register writes
  miso is always driven, peripheral outputs are ORed under mux_sel
*/
`timescale 1ns/1ps

`include "board_ctl_defines.svh"

module spi_route_mux (
  input  logic                      special,
  input  logic                      cs_n,
  input  logic                      sdo,
  input  logic [`BC_NUM_PERIPH-1:0] mux_sel,
  input  logic [`BC_NUM_PERIPH-1:0] periph_miso,
  output logic [`BC_NUM_PERIPH-1:0] periph_cs_n,
  output logic                      miso
);

  logic [`BC_NUM_PERIPH-1:0] sel_miso;   // masked peripheral outputs

  //////////////////////////////////////////////////
  // chip selects

  always_comb
  begin
    if (special)
      periph_cs_n = ~(mux_sel & {`BC_NUM_PERIPH{~cs_n}});   // follow cs_n where selected
    else
      periph_cs_n = '1;   // register write, nobody listens
  end

  //////////////////////////////////////////////////
  // miso

  assign sel_miso = periph_miso & mux_sel;

  always_comb
  begin
    if (special)
      miso = |sel_miso;   // more than one selected just ORs
    else
      miso = sdo;         // fpga register reply
  end

endmodule

//--- source/mask_reg_bank.sv
/*
  eleven 4-bit control registers updated by set/clear/toggle frames
  soft reset address clears all, unknown addresses are ignored
  reply word echoes the last valid address with its register contents
*/
`timescale 1ns/1ps

`include "board_ctl_defines.svh"

module mask_reg_bank
  import board_ctl_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  spi_frame_u                frame,
  input  logic                      frame_valid,
  output logic [`BC_NUM_PERIPH-1:0] mux_sel,
  output logic [`BC_FRAME_BITS-1:0] reply_word,
  output logic [`BC_REG_BITS-1:0]   led,
  output logic [`BC_REG_BITS-1:0]   dac,
  output logic [`BC_REG_BITS-1:0]   rails,
  output logic [`BC_REG_BITS-1:0]   dac_ref_mux,
  output logic [`BC_REG_BITS-1:0]   adc,
  output logic [`BC_REG_BITS-1:0]   clamp1,
  output logic [`BC_REG_BITS-1:0]   clamp2,
  output logic [`BC_REG_BITS-1:0]   relay_com,
  output logic [`BC_REG_BITS-1:0]   irange_sw,
  output logic [`BC_REG_BITS-1:0]   relay
);

  localparam int SLOT_BITS = $clog2(`BC_NUM_REGS);
  localparam int DATA_BITS = `BC_FRAME_BITS - `BC_ADDR_BITS;

  // storage slots
  localparam int SLOT_LED         = 0;
  localparam int SLOT_MUX         = 1;
  localparam int SLOT_DAC         = 2;
  localparam int SLOT_RAILS       = 3;
  localparam int SLOT_DAC_REF_MUX = 4;
  localparam int SLOT_ADC         = 5;
  localparam int SLOT_CLAMP1      = 6;
  localparam int SLOT_CLAMP2      = 7;
  localparam int SLOT_RELAY_COM   = 8;
  localparam int SLOT_IRANGE_SW   = 9;
  localparam int SLOT_RELAY       = 10;

  logic [`BC_REG_BITS-1:0]  regs [`BC_NUM_REGS];
  logic [`BC_ADDR_BITS-1:0] last_addr;      // addr of last valid frame
  logic [SLOT_BITS:0]       wr_slot;        // {hit, index}
  logic [SLOT_BITS:0]       rd_slot;
  logic                     soft_rst;
  frame_byte_t              reply;

  //////////////////////////////////////////////////
  // helpers

  // address to {hit, slot}, miss for soft reset and holes
  function automatic logic [SLOT_BITS:0] addr_slot(input logic [`BC_ADDR_BITS-1:0] a);
    case (a)
      `BC_ADDR_LED:         addr_slot = {1'b1, SLOT_BITS'(SLOT_LED)};
      `BC_ADDR_MUX:         addr_slot = {1'b1, SLOT_BITS'(SLOT_MUX)};
      `BC_ADDR_DAC:         addr_slot = {1'b1, SLOT_BITS'(SLOT_DAC)};
      `BC_ADDR_RAILS:       addr_slot = {1'b1, SLOT_BITS'(SLOT_RAILS)};
      `BC_ADDR_DAC_REF_MUX: addr_slot = {1'b1, SLOT_BITS'(SLOT_DAC_REF_MUX)};
      `BC_ADDR_ADC:         addr_slot = {1'b1, SLOT_BITS'(SLOT_ADC)};
      `BC_ADDR_CLAMP1:      addr_slot = {1'b1, SLOT_BITS'(SLOT_CLAMP1)};
      `BC_ADDR_CLAMP2:      addr_slot = {1'b1, SLOT_BITS'(SLOT_CLAMP2)};
      `BC_ADDR_RELAY_COM:   addr_slot = {1'b1, SLOT_BITS'(SLOT_RELAY_COM)};
      `BC_ADDR_IRANGE_SW:   addr_slot = {1'b1, SLOT_BITS'(SLOT_IRANGE_SW)};
      `BC_ADDR_RELAY:       addr_slot = {1'b1, SLOT_BITS'(SLOT_RELAY)};
      default:              addr_slot = '0;
    endcase
  endfunction

  // any overlap toggles only those bits
  // otherwise set first, then clear
  function automatic logic [`BC_REG_BITS-1:0] apply_masks(
    input logic [`BC_REG_BITS-1:0] cur,
    input logic [`BC_REG_BITS-1:0] clr,
    input logic [`BC_REG_BITS-1:0] set
  );
    logic [`BC_REG_BITS-1:0] both;
    both = clr & set;
    if (both != '0)
      apply_masks = cur ^ both;
    else
      apply_masks = (cur | set) & ~clr;
  endfunction

  //////////////////////////////////////////////////
  // update

  assign wr_slot  = addr_slot(frame.mask.addr);
  assign soft_rst = (frame.mask.addr == `BC_ADDR_SOFT_RST);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      last_addr <= '0;
      for (int i = 0; i < `BC_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (frame_valid)
    begin
      last_addr <= frame.bytes.addr;   // every valid frame, known or not
      if (soft_rst)
      begin
        for (int i = 0; i < `BC_NUM_REGS; i++)
          regs[i] <= '0;
      end
      else if (wr_slot[SLOT_BITS])
        regs[wr_slot[SLOT_BITS-1:0]] <= apply_masks(regs[wr_slot[SLOT_BITS-1:0]],
                                                    frame.mask.clr_mask,
                                                    frame.mask.set_mask);
    end
  end

  //////////////////////////////////////////////////
  // readback

  assign rd_slot = addr_slot(last_addr);

  // address always echoed, data byte 0 when nothing stored there
  always_comb
  begin
    reply.addr = last_addr;
    reply.data = '0;
    if (rd_slot[SLOT_BITS])
      reply.data = DATA_BITS'(regs[rd_slot[SLOT_BITS-1:0]]);   // zero extend
  end

  assign reply_word = reply;

  // pins
  assign mux_sel     = regs[SLOT_MUX][`BC_NUM_PERIPH-1:0];
  assign led         = regs[SLOT_LED];
  assign dac         = regs[SLOT_DAC];
  assign rails       = regs[SLOT_RAILS];
  assign dac_ref_mux = regs[SLOT_DAC_REF_MUX];
  assign adc         = regs[SLOT_ADC];
  assign clamp1      = regs[SLOT_CLAMP1];
  assign clamp2      = regs[SLOT_CLAMP2];
  assign relay_com   = regs[SLOT_RELAY_COM];
  assign irange_sw   = regs[SLOT_IRANGE_SW];
  assign relay       = regs[SLOT_RELAY];

endmodule

//--- source/spi_frame_rx.sv
/*
  spi mode 0 slave, msb first, oversampled in the clk domain
  sclk must be at most clk/6 and cs_n must idle high for 4 clk between frames
  reply_word is loaded when cs_n falls, frame_valid pulses 3 clk after cs_n rises
*/
`timescale 1ns/1ps

`include "board_ctl_defines.svh"

module spi_frame_rx
  import board_ctl_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sclk,
  input  logic                      cs_n,
  input  logic                      mosi,
  input  logic                      special,
  input  logic [`BC_FRAME_BITS-1:0] reply_word,
  output logic                      sdo,
  output spi_frame_u                frame,
  output logic                      frame_valid
);

  localparam int CNT_BITS = $clog2(`BC_FRAME_BITS) + 1;   // room for 17+ edges

  // synchronizer chains plus one stage for edge detect
  logic sclk_s1, sclk_s2, sclk_d;
  logic cs_n_s1, cs_n_s2, cs_n_d;
  logic mosi_s1, mosi_s2;                  // same depth as sclk, stays aligned
  logic special_s1, special_s2;

  logic sclk_rise, sclk_fall;
  logic cs_fall, cs_rise;

  logic [CNT_BITS-1:0]       bit_cnt;      // saturating rising-edge count
  logic                      special_seen; // sticky, special high inside frame
  logic [`BC_FRAME_BITS-1:0] rx_shift;
  logic [`BC_FRAME_BITS-1:0] tx_shift;

  //////////////////////////////////////////////////
  // pin synchronizers

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sclk_s1    <= 1'b0;   // mode 0 idles low
      sclk_s2    <= 1'b0;
      sclk_d     <= 1'b0;
      cs_n_s1    <= 1'b1;   // deselected
      cs_n_s2    <= 1'b1;
      cs_n_d     <= 1'b1;
      mosi_s1    <= 1'b0;
      mosi_s2    <= 1'b0;
      special_s1 <= 1'b0;
      special_s2 <= 1'b0;
    end
    else
    begin
      sclk_s1    <= sclk;
      sclk_s2    <= sclk_s1;
      sclk_d     <= sclk_s2;
      cs_n_s1    <= cs_n;
      cs_n_s2    <= cs_n_s1;
      cs_n_d     <= cs_n_s2;
      mosi_s1    <= mosi;
      mosi_s2    <= mosi_s1;
      special_s1 <= special;
      special_s2 <= special_s1;
    end
  end

  assign sclk_rise = sclk_s2 & ~sclk_d;
  assign sclk_fall = ~sclk_s2 & sclk_d;
  assign cs_fall   = ~cs_n_s2 & cs_n_d;
  assign cs_rise   = cs_n_s2 & ~cs_n_d;

  //////////////////////////////////////////////////
  // frame control

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt      <= '0;
      special_seen <= 1'b0;
      frame_valid  <= 1'b0;
      tx_shift     <= '0;
    end
    else
    begin
      frame_valid <= 1'b0;    // single cycle pulse
      if (cs_fall)
      begin
        bit_cnt      <= '0;
        special_seen <= special_s2;
        tx_shift     <= reply_word;   // first bit out before first rising sclk
      end
      else if (!cs_n_s2)
      begin
        special_seen <= special_seen | special_s2;
        if (sclk_rise && bit_cnt != '1)
          bit_cnt <= bit_cnt + 1'b1;
        if (sclk_fall)
          tx_shift <= {tx_shift[`BC_FRAME_BITS-2:0], 1'b0};   // next bit on falling edge
      end
      // exactly 16 edges and never special
      if (cs_rise)
        frame_valid <= (bit_cnt == CNT_BITS'(`BC_FRAME_BITS)) && !special_seen && !special_s2;
    end
  end

  // payload shifter, msb arrives first
  always_ff @(posedge clk)
  begin
    if (!cs_n_s2 && sclk_rise)
      rx_shift <= {rx_shift[`BC_FRAME_BITS-2:0], mosi_s2};
  end

  assign frame = rx_shift;   // held after cs_n rises, bank latches on frame_valid
  assign sdo   = tx_shift[`BC_FRAME_BITS-1];

endmodule

//--- source/board_ctl_pkg.sv
/*
  frame types for the spi register path
  one received word, read either as addr/data or as addr/clear/set masks
*/
package board_ctl_pkg;

  `include "board_ctl_defines.svh"

  //////////////////////////////////////////////////
  // plain view

  // addr in the high byte, value in the low byte
  typedef struct packed {
    logic [`BC_ADDR_BITS-1:0]                addr;
    logic [`BC_FRAME_BITS-`BC_ADDR_BITS-1:0] data;
  } frame_byte_t;

  //////////////////////////////////////////////////
  // update view

  // high nibble clears, low nibble sets
  // overlapping bits mean toggle
  typedef struct packed {
    logic [`BC_ADDR_BITS-1:0] addr;
    logic [`BC_REG_BITS-1:0]  clr_mask;
    logic [`BC_REG_BITS-1:0]  set_mask;
  } frame_mask_t;

  // both views are exactly one frame wide
  typedef union packed {
    frame_byte_t bytes;   // addr echo, reply path
    frame_mask_t mask;    // register update path
  } spi_frame_u;

endpackage

//--- source/board_ctl_defines.svh
/*
  shared widths and register addresses for the board controller
  register width must stay at 4 since set and clear masks share one data byte
*/
`ifndef BOARD_CTL_DEFINES_SVH
`define BOARD_CTL_DEFINES_SVH

//////////////////////////////////////////////////
// widths

`define BC_FRAME_BITS   16    // one spi frame, addr byte then data byte
`define BC_ADDR_BITS    8     // high byte of the frame
`define BC_REG_BITS     4     // control register width
`define BC_NUM_PERIPH   4     // adc03, dac, flash, adc02
`define BC_NUM_REGS     11    // ten control regs plus the mux reg

//////////////////////////////////////////////////
// register map

`define BC_ADDR_LED          8'd7
`define BC_ADDR_MUX          8'd8     // peripheral select
`define BC_ADDR_DAC          8'd9
`define BC_ADDR_RAILS        8'd10
`define BC_ADDR_SOFT_RST     8'd11    // no storage, clears everything
`define BC_ADDR_DAC_REF_MUX  8'd12
// 13 unused
`define BC_ADDR_ADC          8'd14
`define BC_ADDR_CLAMP1       8'd15
`define BC_ADDR_CLAMP2       8'd16
`define BC_ADDR_RELAY_COM    8'd17
`define BC_ADDR_IRANGE_SW    8'd18
`define BC_ADDR_RELAY        8'd19

`endif
